/* verilog/controlPkg.sv */
package controlPkg;

  typedef enum logic [5:0] {
    rType  = 6'h00,
    opJ    = 6'h02,
    opJal  = 6'h03,
    opBeq  = 6'h04,
    opBne  = 6'h05,
    opAddi = 6'h08,
    opAddiu = 6'h09,
    opSlti = 6'h0A,
    opLui  = 6'h0F,
    opLw   = 6'h23,
    opSw   = 6'h2B
  } opcode_t;

  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnSlt = 6'h2A
  } funct_t;

  // Each funct and opcode variant has its own class so the ALU op follows from it
  typedef enum logic [3:0] {
    aluReg,        // add
    aluRegSub,
    aluRegAnd,
    aluRegSlt,
    aluImm,        // addi
    aluImmSlt,
    aluImmNoTrap,  // addiu
    lui,
    branch,        // beq
    branchNe,
    load,
    store,
    jump,
    jumpLink,
    undefined
  } instrClass_t;

  typedef enum logic [2:0] {
    resetPhase,
    fetch,
    execute,
    exception,
    waitMem
  } phase_t;

  typedef logic [3:0] step_t;

  typedef enum logic [3:0] {
    aluPassA = 4'h0,
    aluAdd   = 4'h1,
    aluSub   = 4'h2,
    aluAnd   = 4'h3,
    aluSlt   = 4'hA,
    aluBeq   = 4'hB,
    aluBne   = 4'hC,
    aluLui   = 4'hF
  } aluOp_t;

  typedef enum logic {causeOpcode, causeOverflow} excCause_t;
  typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget, pcExcVector} pcSrc_t;
  typedef enum logic {srcPc, srcRegA} aluSrcA_t;
  typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcBranchOffset} aluSrcB_t;
  typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDst_t;
  typedef enum logic [1:0] {dataAluOut, dataMem, dataPc} rfData_t;
  typedef enum logic [1:0] {addrPc, addrAluOut, addrExc} memAddr_t;

  typedef struct packed {
    logic      pcWrite;
    logic      epcWrite;
    logic      memWrite;
    logic      irWrite;
    logic      aWrite;
    logic      bWrite;
    logic      aluOutWrite;
    logic      rfWrite;
    logic      mdrWrite;
    pcSrc_t    pcSrc;
    aluSrcA_t  aluSrcA;
    aluSrcB_t  aluSrcB;
    regDst_t   regDst;
    rfData_t   rfData;
    memAddr_t  memAddr;
    excCause_t excCause;
    aluOp_t    aluOp;
  } controlWord_t;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps
module instrDecoder (
  input  logic                    clk,
  input  logic                    reset_in,
  input  controlPkg::opcode_t     opcode,
  input  controlPkg::funct_t      funct,
  input  logic                    decode,
  output controlPkg::instrClass_t instrClass
);
  controlPkg::instrClass_t nextClass;

  always_comb begin
    case (opcode)
      controlPkg::rType: begin
        case (funct)
          controlPkg::fnAdd: nextClass = controlPkg::aluReg;
          controlPkg::fnSub: nextClass = controlPkg::aluRegSub;
          controlPkg::fnAnd: nextClass = controlPkg::aluRegAnd;
          controlPkg::fnSlt: nextClass = controlPkg::aluRegSlt;
          default:           nextClass = controlPkg::undefined;  // Unknown funct
        endcase
      end
      controlPkg::opAddi:  nextClass = controlPkg::aluImm;
      controlPkg::opAddiu: nextClass = controlPkg::aluImmNoTrap;
      controlPkg::opSlti:  nextClass = controlPkg::aluImmSlt;
      controlPkg::opLui:   nextClass = controlPkg::lui;
      controlPkg::opBeq:   nextClass = controlPkg::branch;
      controlPkg::opBne:   nextClass = controlPkg::branchNe;
      controlPkg::opLw:    nextClass = controlPkg::load;
      controlPkg::opSw:    nextClass = controlPkg::store;
      controlPkg::opJ:     nextClass = controlPkg::jump;
      controlPkg::opJal:   nextClass = controlPkg::jumpLink;
      default:             nextClass = controlPkg::undefined;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      instrClass <= controlPkg::undefined;
    end else if (decode) begin
      instrClass <= nextClass;  // Held until the next instruction
    end
  end

  // Decode is a single-cycle strobe from the sequencer
  decodeStrobe: assert property (@(posedge clk) disable iff (reset_in)
    decode |=> !decode);

endmodule

/* verilog/exceptionTracker.sv */
`timescale 1ns/1ps
module exceptionTracker (
  input  logic                    clk,
  input  logic                    reset_in,
  input  logic                    overflow,
  input  controlPkg::instrClass_t instrClass,
  input  logic                    decode,
  input  logic                    excTaken,
  output logic                    pending,
  output controlPkg::excCause_t   cause
);
  logic decodeQ;       // Class register holds the new instruction now
  logic opcodeFlag;
  logic overflowFlag;
  logic undefNew;
  logic overflowHit;

  assign undefNew    = decodeQ && (instrClass == controlPkg::undefined);
  assign overflowHit = overflow && (instrClass != controlPkg::aluImmNoTrap);  // addiu never traps

  always_ff @(posedge clk) begin
    if (reset_in) begin
      decodeQ      <= 1'b0;
      opcodeFlag   <= 1'b0;
      overflowFlag <= 1'b0;
      cause        <= controlPkg::causeOpcode;
    end else begin
      decodeQ <= decode;
      if (excTaken) begin
        opcodeFlag   <= 1'b0;
        overflowFlag <= 1'b0;
      end else begin
        if (undefNew) opcodeFlag <= 1'b1;
        if (overflowHit) overflowFlag <= 1'b1;  // Merges with a pending cause
      end
      // Cause stays valid through the EPC write after the flags clear
      if (undefNew) begin
        cause <= controlPkg::causeOpcode;
      end else if (overflowHit && !opcodeFlag) begin
        cause <= controlPkg::causeOverflow;
      end
    end
  end

  assign pending = opcodeFlag | overflowFlag;

  takenOnlyWhenPending: assert property (@(posedge clk) disable iff (reset_in)
    excTaken |-> pending);

endmodule

/* verilog/stepSequencer.sv */
`timescale 1ns/1ps
module stepSequencer (
  input  logic                    clk,
  input  logic                    reset_in,
  input  controlPkg::instrClass_t instrClass,
  input  logic                    pending,
  input  logic                    branchTaken,
  output controlPkg::phase_t      phase,
  output controlPkg::step_t       step,
  output logic                    decode,
  output logic                    excTaken,
  output logic                    datapathReset
);
  controlPkg::phase_t phaseReg;
  controlPkg::step_t  stepReg;
  controlPkg::step_t  execLen;  // Execute cycles after decode
  logic               trapEntry;
  logic               branchExit;

  always_comb begin
    case (instrClass)
      controlPkg::lui:                          execLen = 4'd4;
      controlPkg::load, controlPkg::store:      execLen = 4'd9;
      controlPkg::jumpLink:                     execLen = 4'd2;
      controlPkg::jump, controlPkg::undefined:  execLen = 4'd0;
      default:                                  execLen = 4'd5;  // ALU forms and taken branch
    endcase
  end

  assign trapEntry  = (phaseReg == controlPkg::fetch) && (stepReg == 4'd0) && pending;
  assign branchExit = (instrClass == controlPkg::branch || instrClass == controlPkg::branchNe) &&
                      (stepReg == 4'd2) && !branchTaken;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phaseReg <= controlPkg::resetPhase;
      stepReg  <= '0;
    end else begin
      stepReg <= stepReg + 4'd1;
      case (phaseReg)
        controlPkg::fetch: begin
          if (trapEntry) begin
            phaseReg <= controlPkg::exception;
            stepReg  <= '0;
          end else if (stepReg == 4'd2) begin
            // Class was loaded at step 1, so its length is known here
            phaseReg <= (execLen == 4'd0) ? controlPkg::fetch : controlPkg::execute;
            stepReg  <= '0;
          end
        end
        controlPkg::execute: begin
          if (branchExit || stepReg == execLen - 4'd1) begin
            phaseReg <= controlPkg::fetch;
            stepReg  <= '0;
          end
        end
        controlPkg::exception: begin
          if (stepReg == 4'd4) begin
            phaseReg <= controlPkg::waitMem;
            stepReg  <= '0;
          end
        end
        controlPkg::waitMem: begin
          if (stepReg == 4'd1) begin
            phaseReg <= controlPkg::fetch;  // Memory now holds the handler word
            stepReg  <= '0;
          end
        end
        default: begin
          phaseReg <= controlPkg::fetch;
          stepReg  <= '0;
        end
      endcase
    end
  end

  // A pending trap turns fetch step 0 into an idle cycle
  always_comb begin
    phase = phaseReg;
    if (trapEntry) begin
      phase = controlPkg::waitMem;
    end
  end

  assign step          = stepReg;
  assign decode        = (phaseReg == controlPkg::fetch) && (stepReg == 4'd1);
  assign excTaken      = (phaseReg == controlPkg::exception) && (stepReg == 4'd0);
  assign datapathReset = reset_in | (phaseReg == controlPkg::resetPhase);

  execStepInRange: assert property (@(posedge clk) disable iff (reset_in)
    phaseReg == controlPkg::execute |-> stepReg < execLen);

endmodule

/* verilog/controlDecoder.sv */
`timescale 1ns/1ps
module controlDecoder (
  input  controlPkg::phase_t       phase,
  input  controlPkg::step_t        step,
  input  controlPkg::instrClass_t  instrClass,
  input  controlPkg::excCause_t    cause,
  output controlPkg::controlWord_t ctrl
);
  controlPkg::aluOp_t classOp;
  logic               regForm;  // Second operand from rt register

  always_comb begin
    case (instrClass)
      controlPkg::aluRegSub:                        classOp = controlPkg::aluSub;
      controlPkg::aluRegAnd:                        classOp = controlPkg::aluAnd;
      controlPkg::aluRegSlt, controlPkg::aluImmSlt: classOp = controlPkg::aluSlt;
      controlPkg::branch:                           classOp = controlPkg::aluBeq;
      controlPkg::branchNe:                         classOp = controlPkg::aluBne;
      controlPkg::lui:                              classOp = controlPkg::aluLui;
      default:                                      classOp = controlPkg::aluAdd;
    endcase
  end

  assign regForm = instrClass inside {controlPkg::aluReg, controlPkg::aluRegSub,
                                      controlPkg::aluRegAnd, controlPkg::aluRegSlt};

  always_comb begin
    ctrl = '0;
    case (phase)
      controlPkg::fetch: begin
        if (step == 4'd0) begin
          ctrl.memAddr     = controlPkg::addrPc;
          ctrl.irWrite     = 1'b1;
          ctrl.aluSrcA     = controlPkg::srcPc;
          ctrl.aluSrcB     = controlPkg::srcFour;
          ctrl.aluOp       = controlPkg::aluAdd;  // PC + 4 into ALUOut
          ctrl.aluOutWrite = 1'b1;
        end else if (step == 4'd2) begin
          ctrl.pcWrite = 1'b1;
          if (instrClass == controlPkg::jump || instrClass == controlPkg::jumpLink) begin
            ctrl.pcSrc = controlPkg::pcJumpTarget;
          end else begin
            ctrl.pcSrc = controlPkg::pcAluOut;
          end
        end
      end
      controlPkg::execute: begin
        case (instrClass)
          controlPkg::aluReg, controlPkg::aluRegSub, controlPkg::aluRegAnd,
          controlPkg::aluRegSlt, controlPkg::aluImm, controlPkg::aluImmSlt,
          controlPkg::aluImmNoTrap: begin
            ctrl.aluSrcA = controlPkg::srcRegA;
            ctrl.aluOp   = classOp;
            ctrl.rfData  = controlPkg::dataAluOut;
            if (regForm) begin
              ctrl.aluSrcB = controlPkg::srcRegB;
              ctrl.regDst  = controlPkg::dstRd;
            end else begin
              ctrl.aluSrcB = controlPkg::srcImm;
              ctrl.regDst  = controlPkg::dstRt;
            end
            ctrl.aWrite      = (step == 4'd0);
            ctrl.bWrite      = (step == 4'd0) && regForm;
            ctrl.aluOutWrite = (step == 4'd1);  // Overflow shows up here
            ctrl.rfWrite     = (step == 4'd2);
          end
          controlPkg::lui: begin
            ctrl.aluSrcB     = controlPkg::srcImm;
            ctrl.aluOp       = classOp;
            ctrl.regDst      = controlPkg::dstRt;
            ctrl.aluOutWrite = (step == 4'd0);
            ctrl.rfWrite     = (step == 4'd2);
          end
          controlPkg::branch, controlPkg::branchNe: begin
            if (step < 4'd3) begin
              ctrl.aluSrcA = controlPkg::srcRegA;  // Compare held through step 2
              ctrl.aluSrcB = controlPkg::srcRegB;
              ctrl.aluOp   = classOp;
              ctrl.aWrite  = (step == 4'd0);
              ctrl.bWrite  = (step == 4'd0);
            end else begin
              ctrl.aluSrcA = controlPkg::srcPc;
              ctrl.aluSrcB = controlPkg::srcBranchOffset;
              ctrl.aluOp   = controlPkg::aluAdd;
              ctrl.pcSrc   = controlPkg::pcAluResult;
              ctrl.pcWrite = (step == 4'd3);
            end
          end
          controlPkg::load, controlPkg::store: begin
            ctrl.aluSrcA     = controlPkg::srcRegA;
            ctrl.aluSrcB     = controlPkg::srcImm;
            ctrl.aluOp       = controlPkg::aluAdd;
            ctrl.aWrite      = (step == 4'd0);
            ctrl.bWrite      = (step == 4'd0) && (instrClass == controlPkg::store);
            ctrl.aluOutWrite = (step == 4'd1);
            if (step >= 4'd2) ctrl.memAddr = controlPkg::addrAluOut;
            if (instrClass == controlPkg::load) begin
              ctrl.rfData   = controlPkg::dataMem;
              ctrl.regDst   = controlPkg::dstRt;
              ctrl.mdrWrite = (step == 4'd4);
              ctrl.rfWrite  = (step == 4'd6);
            end else begin
              ctrl.memWrite = (step == 4'd6) || (step == 4'd7);
            end
          end
          controlPkg::jumpLink: begin
            ctrl.regDst  = controlPkg::dstRa;
            ctrl.rfData  = controlPkg::dataPc;
            ctrl.rfWrite = (step == 4'd0);
          end
          default: ;
        endcase
      end
      controlPkg::exception: begin
        ctrl.excCause = cause;
        if (step < 4'd2) ctrl.memAddr = controlPkg::addrExc;  // Handler address lookup
        if (step == 4'd0) begin
          ctrl.aluSrcA     = controlPkg::srcPc;
          ctrl.aluSrcB     = controlPkg::srcFour;
          ctrl.aluOp       = controlPkg::aluSub;
          ctrl.aluOutWrite = 1'b1;
        end else if (step == 4'd2) begin
          ctrl.epcWrite = 1'b1;
          ctrl.pcWrite  = 1'b1;
          ctrl.pcSrc    = controlPkg::pcExcVector;
        end
      end
      default: ;  // Reset and memory wait are idle
    endcase
  end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
module controlUnit (
  input  logic                     clk,
  input  logic                     reset_in,
  input  controlPkg::opcode_t      opcode,
  input  controlPkg::funct_t       funct,
  input  logic                     branchTaken,
  input  logic                     overflow,
  output controlPkg::controlWord_t ctrl,
  output logic                     datapathReset
);
  controlPkg::instrClass_t instrClass;
  controlPkg::phase_t      phase;
  controlPkg::step_t       step;
  controlPkg::excCause_t   cause;
  logic                    decode;
  logic                    excTaken;
  logic                    pending;

  instrDecoder i_instrDecoder (
    .clk(clk), .reset_in(reset_in), .opcode(opcode), .funct(funct),
    .decode(decode), .instrClass(instrClass)
  );

  exceptionTracker i_exceptionTracker (
    .clk(clk), .reset_in(reset_in), .overflow(overflow), .instrClass(instrClass),
    .decode(decode), .excTaken(excTaken), .pending(pending), .cause(cause)
  );

  stepSequencer i_stepSequencer (
    .clk(clk), .reset_in(reset_in), .instrClass(instrClass), .pending(pending),
    .branchTaken(branchTaken), .phase(phase), .step(step), .decode(decode),
    .excTaken(excTaken), .datapathReset(datapathReset)
  );

  controlDecoder i_controlDecoder (
    .phase(phase), .step(step), .instrClass(instrClass), .cause(cause), .ctrl(ctrl)
  );

endmodule

/* verif/controlRef.svh */
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

// Raw MIPS encodings of the kept instructions
function automatic bit isRegAlu(input logic [5:0] op, input logic [5:0] fn);
  return (op == 6'h00) && (fn == 6'h20 || fn == 6'h22 || fn == 6'h24 || fn == 6'h2A);
endfunction

function automatic bit isUndefined(input logic [5:0] op, input logic [5:0] fn);
  case (op)
    6'h00: return !isRegAlu(op, fn);
    6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h09, 6'h0A, 6'h0F, 6'h23, 6'h2B: return 1'b0;
    default: return 1'b1;
  endcase
endfunction

function automatic int execCycles(input logic [5:0] op, input logic [5:0] fn, input logic taken);
  if (isUndefined(op, fn)) return 0;
  case (op)
    6'h00, 6'h08, 6'h09, 6'h0A: return 5;
    6'h0F: return 4;  // lui
    6'h04, 6'h05: return taken ? 5 : 3;
    6'h23, 6'h2B: return 9;
    6'h03: return 2;  // jal
    default: return 0;  // j
  endcase
endfunction

// Overflow traps on add, sub, addi and slti but never on addiu
function automatic bit trapExpected(input logic [5:0] op, input logic [5:0] fn, input logic ovf);
  return isUndefined(op, fn) ||
         (ovf && (isRegAlu(op, fn) || op == 6'h08 || op == 6'h0A));
endfunction

function automatic int expInterval(input logic [5:0] op, input logic [5:0] fn,
                                   input logic taken, input logic ovf);
  return 3 + execCycles(op, fn, taken) + (trapExpected(op, fn, ovf) ? 8 : 0);
endfunction

function automatic int expRfWrites(input logic [5:0] op, input logic [5:0] fn);
  if (isUndefined(op, fn)) return 0;
  case (op)
    6'h00, 6'h08, 6'h09, 6'h0A, 6'h0F, 6'h23, 6'h03: return 1;
    default: return 0;
  endcase
endfunction

function automatic int expMemWrites(input logic [5:0] op);
  return (op == 6'h2B) ? 2 : 0;  // Store holds memWrite for two cycles
endfunction

function automatic int expPcWrites(input logic [5:0] op, input logic [5:0] fn,
                                   input logic taken, input logic ovf);
  return 1 + (((op == 6'h04) || (op == 6'h05)) && taken ? 1 : 0) +
         (trapExpected(op, fn, ovf) ? 1 : 0);
endfunction

`endif

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps
module controlUnitTb;
  localparam int NUM = 80;  // Checked instructions, one filler follows

  logic                     clk;
  logic                     reset_in;
  controlPkg::opcode_t      opcode;
  controlPkg::funct_t       funct;
  logic                     branchTaken;
  logic                     overflow;
  controlPkg::controlWord_t ctrl;
  logic                     datapathReset;

  logic [5:0] opList    [0:NUM];
  logic [5:0] fnList    [0:NUM];
  logic       takenList [0:NUM];
  logic       ovfList   [0:NUM];

  int cyc;
  int rfCnt;
  int memCnt;
  int pcCnt;
  int epcCnt;
  int winIdx;
  int checkedCount;
  bit started;

  `include "controlRef.svh"

  controlUnit i_controlUnit (
    .clk(clk), .reset_in(reset_in), .opcode(opcode), .funct(funct),
    .branchTaken(branchTaken), .overflow(overflow), .ctrl(ctrl), .datapathReset(datapathReset)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Low bits of non-R words act as the immediate
  function automatic logic [11:0] candidate(input logic [3:0] sel, input logic [5:0] imm);
    case (sel)
      4'd0: return {6'h00, 6'h20};  // add
      4'd1: return {6'h00, 6'h22};
      4'd2: return {6'h00, 6'h24};
      4'd3: return {6'h00, 6'h2A};
      4'd4: return {6'h00, 6'h00};  // sll is not kept
      4'd5: return {6'h08, imm};
      4'd6: return {6'h09, imm};  // addiu
      4'd7: return {6'h0A, imm};
      4'd8: return {6'h0F, imm};
      4'd9: return {6'h04, imm};
      4'd10: return {6'h05, imm};
      4'd11: return {6'h23, imm};
      4'd12: return {6'h2B, imm};
      4'd13: return {6'h02, imm};
      4'd14: return {6'h03, imm};
      default: return {6'h20, imm};  // lb is not kept
    endcase
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      failRun("Control output differs from the expected value");
    end
  endtask

  // First 32 walk the menu twice with taken and overflow set on the second pass
  task automatic buildProgram();
    logic [31:0] rnd;
    logic [3:0]  sel;
    logic [11:0] pair;
    rnd = 32'h8ec6_2fc3;
    for (int i = 0; i < NUM; i++) begin
      rnd = xorshift32(rnd);
      sel = (i < 32) ? 4'(i) : rnd[3:0];
      pair = candidate(sel, rnd[21:16]);
      opList[i] = pair[11:6];
      fnList[i] = pair[5:0];
      takenList[i] = (i < 32) ? (i >= 16) : rnd[8];
      ovfList[i] = (sel == 4'd0 || sel == 4'd1 || sel == 4'd5 || sel == 4'd6) &&
                   ((i < 32) ? (i >= 16) : rnd[9]);
    end
    opList[NUM] = 6'h02;  // Filler jump closes the last window
    fnList[NUM] = 6'h00;
    takenList[NUM] = 1'b0;
    ovfList[NUM] = 1'b0;
  endtask

  task automatic awaitStrobe(input bit irSel, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 40) failRun({"Timeout while waiting for ", what});
    end while (!(irSel ? ctrl.irWrite : ctrl.aluOutWrite));
  endtask

  task automatic presentInstr(input int k);
    opcode = controlPkg::opcode_t'(opList[k]);
    funct = controlPkg::funct_t'(fnList[k]);
    branchTaken = takenList[k];
    if (ovfList[k]) begin
      awaitStrobe(1'b0, "execute step 1 of an ALU instruction");
      overflow = 1'b1;  // One cycle wide
      @(negedge clk);
      overflow = 1'b0;
    end
  endtask

  task automatic closeWindow(input int idx);
    logic [5:0] op;
    logic [5:0] fn;
    op = opList[idx];
    fn = fnList[idx];
    checkValue($sformatf("irWrite interval of instr %0d", idx), 32'(cyc),
               32'(expInterval(op, fn, takenList[idx], ovfList[idx])));
    checkValue($sformatf("rfWrite count of instr %0d", idx), 32'(rfCnt),
               32'(expRfWrites(op, fn)));
    checkValue($sformatf("memWrite count of instr %0d", idx), 32'(memCnt),
               32'(expMemWrites(op)));
    checkValue($sformatf("pcWrite count of instr %0d", idx), 32'(pcCnt),
               32'(expPcWrites(op, fn, takenList[idx], ovfList[idx])));
    checkValue($sformatf("epcWrite count of instr %0d", idx), 32'(epcCnt),
               32'(trapExpected(op, fn, ovfList[idx]) ? 1 : 0));
    checkedCount++;
  endtask

  // Monitor samples on the rising edge while inputs move on the falling edge
  always @(posedge clk) begin
    if (datapathReset) begin
      checkValue("strobes in reset", 32'({ctrl.pcWrite, ctrl.epcWrite, ctrl.memWrite,
                 ctrl.irWrite, ctrl.aWrite, ctrl.bWrite, ctrl.aluOutWrite, ctrl.rfWrite,
                 ctrl.mdrWrite}), 0);
    end else begin
      if (ctrl.irWrite) begin
        if (started) begin
          closeWindow(winIdx);
          winIdx++;
        end
        started = 1'b1;
        cyc = 0;
        rfCnt = 0;
        memCnt = 0;
        pcCnt = 0;
        epcCnt = 0;
      end
      cyc++;
      if (ctrl.pcWrite) begin
        if (pcCnt == 0) begin  // Decode step
          checkValue("pcSrc", 32'(ctrl.pcSrc),
                     (opList[winIdx] == 6'h02 || opList[winIdx] == 6'h03) ?
                     32'(controlPkg::pcJumpTarget) : 32'(controlPkg::pcAluOut));
        end
        pcCnt++;
      end
      if (ctrl.rfWrite) begin
        if (opList[winIdx] == 6'h03) checkValue("regDst", 32'(ctrl.regDst),
                                                32'(controlPkg::dstRa));
        rfCnt++;
      end
      if (ctrl.memWrite) memCnt++;
      if (ctrl.epcWrite) begin
        checkValue("excCause", 32'(ctrl.excCause), isUndefined(opList[winIdx], fnList[winIdx]) ?
                   32'(controlPkg::causeOpcode) : 32'(controlPkg::causeOverflow));
        epcCnt++;
      end
    end
  end

  initial begin
    int cnt;
    reset_in = 1'b1;
    opcode = controlPkg::rType;
    funct = controlPkg::fnAdd;
    branchTaken = 1'b0;
    overflow = 1'b0;
    cyc = 0;
    rfCnt = 0;
    memCnt = 0;
    pcCnt = 0;
    epcCnt = 0;
    winIdx = 0;
    checkedCount = 0;
    started = 1'b0;
    buildProgram();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_in = 1'b0;
    cnt = 0;
    while (datapathReset) begin
      @(negedge clk);
      cnt++;
      if (cnt > 5) failRun("datapathReset stayed high after reset was released");
    end
    checkValue("datapathReset cycles after reset", 32'(cnt), 1);
    checkValue("irWrite after reset", 32'(ctrl.irWrite), 1);
    presentInstr(0);
    for (int k = 1; k <= NUM; k++) begin
      awaitStrobe(1'b1, "the next irWrite");
      presentInstr(k);
    end
    cnt = 0;
    while (checkedCount < NUM && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (checkedCount == NUM) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      failRun("Timeout while waiting for the last instruction check");
    end
  end

endmodule

/* project.f */
+incdir+verif
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/exceptionTracker.sv
verilog/stepSequencer.sv
verilog/controlDecoder.sv
verilog/controlUnit.sv
verif/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
out=$(verilator --binary --timing --assert -f project.f --top-module controlUnitTb 2>&1 &&
  ./obj_dir/VcontrolUnitTb 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
